// ==== hdl/uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

  // start, 8 data, even parity, stop
  parameter int FRAME_BITS = 11;

  // bit 15 selects the operation, low byte unused on a read
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] wdata;
  } cmd_t;

  typedef struct packed {
    logic [7:0] rdata;      // zero on timeout
    logic       parity_err; // also covers a bad stop bit
    logic       timeout;
  } rsp_t;

  // receiver result, handed to the sequencer with rx_vld
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;  // stop bit sampled low
  } rx_byte_t;

  // line order, bit 0 goes out first
  typedef struct packed {
    logic       stop;
    logic       parity;
    logic [7:0] data;
    logic       start;
  } frame_t;

endpackage

`default_nettype wire

// ==== hdl/uart_tx_frame.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame #(
  parameter int BIT_CYCLES = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] tx_data,
  input  logic       tx_start,
  output logic       tx_busy,
  output logic       tx
);
  import uart_cmd_pkg::*;

  localparam int CW = $clog2(BIT_CYCLES + 1);
  localparam int IW = $clog2(FRAME_BITS);

  frame_t                  load_frame;
  frame_t                  frame;
  logic [FRAME_BITS-1:0]   frame_bits;
  logic [CW-1:0]           cyc_cnt;
  logic [IW-1:0]           bit_idx;
  logic                    bit_end;

  assign load_frame = '{stop: 1'b1, parity: ^tx_data, data: tx_data, start: 1'b0};
  assign frame_bits = frame;
  assign bit_end    = (cyc_cnt == CW'(BIT_CYCLES - 1));

  always_ff @(posedge clk)
  begin
    if (tx_start)
      frame <= load_frame;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy <= 1'b0;
      tx      <= 1'b1;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end
    else if (tx_start)
    begin
      tx_busy <= 1'b1;
      tx      <= load_frame.start; // start bit out right away
      cyc_cnt <= '0;
      bit_idx <= '0;
    end
    else if (tx_busy)
    begin
      if (bit_end)
      begin
        cyc_cnt <= '0;
        if (bit_idx == IW'(FRAME_BITS - 1))
        begin
          tx_busy <= 1'b0; // stop bit done
          tx      <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
          tx      <= frame_bits[bit_idx + 1'b1];
        end
      end
      else
        cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  // sequencer must wait for the previous frame
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
    else $error("tx_start while frame in progress");

endmodule

`default_nettype wire

// ==== hdl/uart_rx_frame.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame #(
  parameter int BIT_CYCLES = 434
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  input  logic                    rx_en,
  output uart_cmd_pkg::rx_byte_t  rx_byte,
  output logic                    rx_vld
);
  import uart_cmd_pkg::*;

  localparam int CW       = $clog2(BIT_CYCLES + 1);
  localparam int IW       = $clog2(FRAME_BITS);
  localparam int HALF     = BIT_CYCLES / 2;
  localparam int STOP_IDX = FRAME_BITS - 2; // index after start: data 0..7, parity, stop

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS
  } rx_state_t;

  rx_state_t      state;
  logic           rx_meta;
  logic           rx_sync;
  logic           rx_prev;
  logic           fall;
  logic [CW-1:0]  cyc_cnt;
  logic [IW-1:0]  bit_idx;
  logic           bit_end;
  logic           sample;
  logic [8:0]     shreg;    // data lsb first, parity on top

  assign fall    = rx_prev & ~rx_sync;
  assign bit_end = (cyc_cnt == CW'(BIT_CYCLES - 1));
  assign sample  = rx_en && (state == RX_BITS) && bit_end;

  // line idles high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= RX_IDLE;
      cyc_cnt <= '0;
      bit_idx <= '0;
      rx_vld  <= 1'b0;
    end
    else
    begin
      rx_vld <= 1'b0;
      if (!rx_en)
        state <= RX_IDLE;
      else
      begin
        case (state)
          RX_IDLE:
          begin
            if (fall)
            begin
              state   <= RX_START;
              cyc_cnt <= '0;
            end
          end
          RX_START:
          begin
            if (cyc_cnt == CW'(HALF - 1))
            begin
              cyc_cnt <= '0;
              bit_idx <= '0;
              state   <= rx_sync ? RX_IDLE : RX_BITS; // high here means a glitch
            end
            else
              cyc_cnt <= cyc_cnt + 1'b1;
          end
          RX_BITS:
          begin
            if (bit_end)
            begin
              cyc_cnt <= '0;
              if (bit_idx == IW'(STOP_IDX))
              begin
                rx_vld <= 1'b1;
                state  <= RX_IDLE;
              end
              else
                bit_idx <= bit_idx + 1'b1;
            end
            else
              cyc_cnt <= cyc_cnt + 1'b1;
          end
          default: state <= RX_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx == IW'(STOP_IDX))
      begin
        rx_byte.data       <= shreg[7:0];
        rx_byte.parity_err <= ^shreg; // even parity over data and parity bit
        rx_byte.frame_err  <= ~rx_sync;
      end
      else
        shreg <= {rx_sync, shreg[8:1]};
    end
  end

  a_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_vld |=> !rx_vld)
    else $error("rx_vld longer than one cycle");

endmodule

`default_nettype wire

// ==== hdl/uart_cmd_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_master #(
  parameter int BIT_CYCLES       = 434,
  parameter int GAP_BITS         = 2,
  parameter int RSP_TIMEOUT_BITS = 32
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_t      cmd,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  output uart_cmd_pkg::rsp_t      rsp,
  output logic                    rsp_vld,
  output logic [7:0]              tx_data,
  output logic                    tx_start,
  input  logic                    tx_busy,
  output logic                    rx_en,
  input  uart_cmd_pkg::rx_byte_t  rx_byte,
  input  logic                    rx_vld
);
  import uart_cmd_pkg::*;

  localparam int GAP_CYCLES = GAP_BITS * BIT_CYCLES;
  localparam int RSP_CYCLES = RSP_TIMEOUT_BITS * BIT_CYCLES;
  // gap cycle 0 is spent seeing busy low, the last one carries tx_start
  localparam int GAP_LAST   = (GAP_CYCLES > 2) ? GAP_CYCLES - 2 : 1;
  localparam int CNT_MAX    = (GAP_CYCLES > RSP_CYCLES) ? GAP_CYCLES : RSP_CYCLES;
  localparam int CW         = $clog2(CNT_MAX + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_HI,
    ST_GAP,
    ST_SEND_LO,
    ST_WAIT_RSP
  } state_t;

  state_t         state;
  cmd_t           cmd_buf;
  logic [CW-1:0]  cnt;      // gap and response window
  logic           tx_idle;
  logic           accept;
  logic           rd_done;
  logic           rd_timeout;

  assign tx_idle    = !tx_start && !tx_busy;
  assign rx_en      = (state == ST_WAIT_RSP);
  assign rd_done    = rx_en && rx_vld;
  assign rd_timeout = rx_en && !rx_vld && (cnt == CW'(RSP_CYCLES - 1));

  assign rsp_vld = ((state == ST_SEND_LO) && tx_idle) || rd_done || rd_timeout;
  assign cmd_rdy = (state == ST_IDLE) || rsp_vld; // next command may start on the response cycle
  assign accept  = cmd_vld && cmd_rdy;

  assign tx_data = (state == ST_SEND_LO) ? cmd_buf.wdata : {cmd_buf.write, cmd_buf.addr};

  always_comb
  begin
    rsp = '0;
    if (rd_done)
    begin
      rsp.rdata      = rx_byte.data;
      rsp.parity_err = rx_byte.parity_err | rx_byte.frame_err;
    end
    rsp.timeout = rd_timeout;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_buf <= cmd;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      cnt      <= '0;
      tx_start <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        ST_SEND_HI:
        begin
          if (tx_idle)
          begin
            cnt   <= cmd_buf.write ? CW'(1) : '0;
            state <= cmd_buf.write ? ST_GAP : ST_WAIT_RSP;
          end
        end
        ST_GAP:
        begin
          if (cnt == CW'(GAP_LAST))
          begin
            tx_start <= 1'b1; // data byte
            state    <= ST_SEND_LO;
          end
          else
            cnt <= cnt + 1'b1;
        end
        ST_SEND_LO:
        begin
          if (tx_idle)
            state <= ST_IDLE;
        end
        ST_WAIT_RSP:
        begin
          if (rsp_vld)
            state <= ST_IDLE;
          else
            cnt <= cnt + 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
      if (accept)
      begin
        state    <= ST_SEND_HI;
        tx_start <= 1'b1; // address byte
      end
    end
  end

  // a response always closes a command that was taken earlier
  a_rsp_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_vld |-> !$past(cmd_rdy))
    else $error("rsp_vld without command in flight");

  a_tx_rx_excl: assert property (@(posedge clk) disable iff (!rst_n) !(tx_start && rx_en))
    else $error("tx_start while waiting for response");

endmodule

`default_nettype wire

// ==== hdl/uart_cmd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top #(
  parameter int BIT_CYCLES       = 434,
  parameter int GAP_BITS         = 2,
  parameter int RSP_TIMEOUT_BITS = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_cmd_pkg::cmd_t  cmd,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output uart_cmd_pkg::rsp_t  rsp,
  output logic                rsp_vld,
  output logic                tx,
  input  logic                rx    // async to clk
);
  import uart_cmd_pkg::*;

  logic [7:0]  tx_data;
  logic        tx_start;
  logic        tx_busy;
  logic        rx_en;
  logic        rx_vld;
  rx_byte_t    rx_byte;

  uart_cmd_master #(
    .BIT_CYCLES       (BIT_CYCLES),
    .GAP_BITS         (GAP_BITS),
    .RSP_TIMEOUT_BITS (RSP_TIMEOUT_BITS)
  ) u_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rsp      (rsp),
    .rsp_vld  (rsp_vld),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .rx_en    (rx_en),
    .rx_byte  (rx_byte),
    .rx_vld   (rx_vld)
  );

  uart_tx_frame #(
    .BIT_CYCLES (BIT_CYCLES)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx_frame #(
    .BIT_CYCLES (BIT_CYCLES)
  ) u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_en   (rx_en),
    .rx_byte (rx_byte),
    .rx_vld  (rx_vld)
  );

endmodule

`default_nettype wire

// ==== testbench/uart_remote_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_remote_model #(
  parameter int BIT_CYCLES = 434
) (
  input  logic clk,
  input  logic tx,          // from the master
  output logic rx,          // answers back to the master
  output int   frame_errs   // bad parity or stop bit seen on tx
);
  import uart_cmd_pkg::*;

  logic [7:0] regs [0:127];
  logic [6:0] addr;
  logic       wr_pending;
  logic [7:0] rbyte;

  // returns at mid stop bit
  task automatic recv_frame(output logic [7:0] data);
    logic [FRAME_BITS-2:0] bits;  // data, parity, stop
    int i;
    @(negedge tx);
    repeat (BIT_CYCLES / 2) @(posedge clk);
    for (i = 0; i < FRAME_BITS - 1; i++)
    begin
      repeat (BIT_CYCLES) @(posedge clk);
      bits[i] = tx;
    end
    if (bits[8] != ^bits[7:0] || !bits[9])
    begin
      frame_errs = frame_errs + 1;
      $display("mismatch at %0d ns: tx frame %h has a bad parity or stop bit", $time, bits);
    end
    data = bits[7:0];
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [FRAME_BITS-1:0] bits;
    int i;
    bits = {1'b1, (^data) ^ bad_parity, data, 1'b0};
    for (i = 0; i < FRAME_BITS; i++)
    begin
      rx <= bits[i];
      // line stays high after half a stop bit
      repeat ((i == FRAME_BITS - 1) ? BIT_CYCLES / 2 : BIT_CYCLES) @(posedge clk);
    end
  endtask

  initial
  begin
    int a;
    rx <= 1'b1;
    frame_errs = 0;
    wr_pending = 1'b0;
    for (a = 0; a < 128; a++)
      regs[a] = '0;
    forever
    begin
      recv_frame(rbyte);
      if (wr_pending)
      begin
        regs[addr] = rbyte;  // data byte of a write
        wr_pending = 1'b0;
      end
      else if (rbyte[7])
      begin
        addr       = rbyte[6:0];
        wr_pending = 1'b1;
      end
      else if (rbyte[6:0] != 7'h7f)  // 0x7f stays silent
      begin
        repeat (3 * BIT_CYCLES) @(posedge clk);
        send_frame(regs[rbyte[6:0]], rbyte[6:0] == 7'h7e);
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_uart_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd;
  import uart_cmd_pkg::*;

  localparam int BIT_CYCLES       = 8;
  localparam int GAP_BITS         = 2;
  localparam int RSP_TIMEOUT_BITS = 32;
  // transfer to response edge plus one cycle each for tx_start and rsp_vld
  localparam int WR_LATENCY  = 2 * FRAME_BITS * BIT_CYCLES + GAP_BITS * BIT_CYCLES + 2;
  localparam int CASE_CYCLES = (2 * FRAME_BITS + GAP_BITS + RSP_TIMEOUT_BITS) * BIT_CYCLES;

  logic        clk;
  logic        rst_n;
  cmd_t        cmd;
  logic        cmd_vld;
  logic        cmd_rdy;
  rsp_t        rsp;
  logic        rsp_vld;
  logic        tx;
  logic        rx;
  int          remote_errors;

  int          case_op[$];  // 0 listed, 1 random write, 2 shadow read
  cmd_t        case_cmd[$];
  rsp_t        case_rsp[$];
  rsp_t        exp_q[$];
  cmd_t        sent_q[$];
  logic [7:0]  shadow [0:127];
  logic [31:0] rand_state;
  int          max_cycles;
  int          run_errors;

  int          cycle = 0;
  int          mismatches = 0;
  int          proto_errors = 0;
  int          n_xfer = 0;
  int          xfer_cycle = 0;
  logic        xfer_write = 1'b0;
  logic        in_flight = 1'b0;

  uart_cmd_top #(
    .BIT_CYCLES       (BIT_CYCLES),
    .GAP_BITS         (GAP_BITS),
    .RSP_TIMEOUT_BITS (RSP_TIMEOUT_BITS)
  ) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .rsp     (rsp),
    .rsp_vld (rsp_vld),
    .tx      (tx),
    .rx      (rx)
  );

  uart_remote_model #(
    .BIT_CYCLES (BIT_CYCLES)
  ) u_remote (
    .clk        (clk),
    .tx         (tx),
    .rx         (rx),
    .frame_errs (remote_errors)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // random cases chain without dropping cmd_vld
  function automatic logic keeps_valid(input int idx);
    return (case_op[idx] != 0) && (idx + 1 < case_op.size()) && (case_op[idx + 1] != 0);
  endfunction

  task automatic load_cases();
    int          fd;
    int          cnt;
    int          op;
    int          pe;
    int          to;
    logic [15:0] word;
    logic [7:0]  rd;
    string       line;
    fd = $fopen("testbench/uart_cmd_cases.txt", "r");
    if (fd == 0)
    begin
      run_errors = run_errors + 1;
      $display("cannot open testbench/uart_cmd_cases.txt");
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 1 && line.getc(0) != "#")
        begin
          cnt = $sscanf(line, "%d %h %h %d %d", op, word, rd, pe, to);
          if (cnt == 5)
          begin
            case_op.push_back(op);
            case_cmd.push_back(word);
            case_rsp.push_back('{rdata: rd, parity_err: pe[0], timeout: to[0]});
          end
          else
          begin
            run_errors = run_errors + 1;
            $display("case file line not understood: %s", line);
          end
        end
      end
      $fclose(fd);
      if (case_op.size() == 0)
      begin
        run_errors = run_errors + 1;
        $display("case file holds no cases");
      end
    end
  endtask

  // call on a rising edge
  task automatic issue_command(input int idx);
    cmd_t c;
    rsp_t want;
    c    = case_cmd[idx];
    want = case_rsp[idx];
    if (case_op[idx] == 1)
    begin
      rand_state = xorshift32(rand_state);
      c.write    = 1'b1;
      c.wdata    = rand_state[7:0];
      want       = '0;
    end
    else if (case_op[idx] == 2)
    begin
      c.write = 1'b0;
      want    = '{rdata: shadow[c.addr], parity_err: 1'b0, timeout: 1'b0};
    end
    if (c.write)
      shadow[c.addr] = c.wdata;
    exp_q.push_back(want);
    sent_q.push_back(c);
    cmd     <= c;
    cmd_vld <= 1'b1;
  endtask

  task automatic wait_accept();
    @(posedge clk);
    while (!cmd_rdy)
      @(posedge clk);
  endtask

  task automatic wait_response();
    @(posedge clk);
    while (!rsp_vld)
      @(posedge clk);
  endtask

  task automatic check_response();
    rsp_t want;
    cmd_t sent;
    if (!in_flight || exp_q.size() == 0)
    begin
      proto_errors = proto_errors + 1;
      $display("%0d ns: response with no command in flight", $time);
    end
    else
    begin
      want      = exp_q.pop_front();
      sent      = sent_q.pop_front();
      in_flight = 1'b0;
      if (rsp !== want)
      begin
        mismatches = mismatches + 1;
        $display("mismatch at %0d ns: cmd %h expected rdata %h perr %b tmo %b, got %h %b %b",
                 $time, sent, want.rdata, want.parity_err, want.timeout,
                 rsp.rdata, rsp.parity_err, rsp.timeout);
      end
      if (xfer_write && (cycle - xfer_cycle != WR_LATENCY))
      begin
        mismatches = mismatches + 1;
        $display("mismatch at %0d ns: write %h answered after %0d cycles, expected %0d",
                 $time, sent, cycle - xfer_cycle, WR_LATENCY);
      end
    end
  endtask

  // cycle count, watchdog and response checks
  always @(posedge clk)
  begin
    cycle = cycle + 1;
    if (cycle >= max_cycles)
    begin
      $display("run timed out after %0d cycles, %0d of %0d commands taken, %0d mismatches",
               cycle, n_xfer, case_op.size(), mismatches);
      $display("Verification failed");
      $finish;
    end
    else if (rst_n)
    begin
      if (rsp_vld)
      begin
        check_response();
        if (!cmd_rdy)
        begin
          proto_errors = proto_errors + 1;
          $display("%0d ns: cmd_rdy low on the response cycle", $time);
        end
      end
      else if (in_flight && cmd_rdy)
      begin
        proto_errors = proto_errors + 1;
        $display("%0d ns: cmd_rdy high while a command is in flight", $time);
      end
      if (cmd_vld && cmd_rdy)
      begin
        in_flight  = 1'b1;
        xfer_cycle = cycle;
        xfer_write = cmd.write;
        n_xfer     = n_xfer + 1;
      end
    end
  end

  initial
  begin
    int i;
    clk        = 1'b0;
    rst_n      <= 1'b0;
    cmd        <= '0;
    cmd_vld    <= 1'b0;
    rand_state = 32'd85728;
    run_errors = 0;
    for (i = 0; i < 128; i++)
      shadow[i] = '0;
    load_cases();
    max_cycles = (case_op.size() + 4) * CASE_CYCLES;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (i = 0; i < case_op.size(); i++)
    begin
      issue_command(i);
      wait_accept();
      if (!keeps_valid(i))
      begin
        cmd_vld <= 1'b0;
        wait_response();
      end
    end
    repeat (4) @(posedge clk);
    if (n_xfer != case_op.size())
    begin
      run_errors = run_errors + 1;
      $display("%0d commands taken by the DUT, %0d issued", n_xfer, case_op.size());
    end
    $display("%0d cases: %0d mismatches, %0d protocol, %0d tx frame, %0d run errors",
             case_op.size(), mismatches, proto_errors, remote_errors, run_errors);
    if (mismatches + proto_errors + remote_errors + run_errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/uart_cmd_cases.txt ====
# op cmd rdata parity_err timeout (op decimal, cmd and rdata hex, flags 0 or 1)
# op 0 checks the listed response, op 1 random write and op 2 shadow read run back to back
0 8a5c 00 0 0
0 0a00 5c 0 0
0 0b00 00 0 0
0 7f00 00 0 1
0 7e00 00 1 0
0 fea5 00 0 0
0 7e00 a5 1 0
0 ff3c 00 0 0
0 7f00 00 0 1
0 80c3 00 0 0
0 0000 c3 0 0
1 9100 00 0 0
1 a200 00 0 0
2 1100 00 0 0
1 b300 00 0 0
2 2200 00 0 0
2 3300 00 0 0
1 9100 00 0 0
2 1100 00 0 0
2 4400 00 0 0
1 c400 00 0 0
1 d500 00 0 0
2 5500 00 0 0
2 4400 00 0 0
2 0a00 00 0 0
0 0a00 5c 0 0

// ==== src.f ====
hdl/uart_cmd_pkg.sv
hdl/uart_tx_frame.sv
hdl/uart_rx_frame.sv
hdl/uart_cmd_master.sv
hdl/uart_cmd_top.sv
testbench/uart_remote_model.sv
testbench/tb_uart_cmd.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 -f src.f --top-module tb_uart_cmd -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_uart_cmd > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
  echo "run.sh: simulation passed"
  exit 0
else
  echo "run.sh: pass message not found in $LOG"
  exit 1
fi
